// File: all.f
hw/outstanding_pkg.sv
hw/outstanding_intf.sv
hw/mem_array.sv
hw/latency_timer.sv
hw/resp_return_fsm.sv
hw/outstanding_rob.sv
hw/outstanding_top.sv
sim/tb_clk_gen.sv
sim/tb_outstanding_top.sv

// File: hw/latency_timer.sv
//////////////////////////////
// Target slot store, serves a request on accept and holds
// its response for a bank dependent number of cycles
//////////////////////////////

`default_nettype none

module latency_timer
  import outstanding_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Request side of the target
  outstanding_intf.target          tgt,

  // Memory port
  output logic                     mem_wr_en,
  output logic [AW-1:0]            mem_wr_add,
  output logic [BW-1:0]            mem_wr_be,
  output logic [DW-1:0]            mem_wr_data,
  output logic [AW-1:0]            mem_rd_add,
  input  logic [DW-1:0]            mem_rd_data,
  input  logic                     mem_in_range,

  // Slot state toward the return FSM
  output logic [ROB_NW-1:0]        expired,
  output slot_entry_t [ROB_NW-1:0] entries,
  input  logic                     release_slot_valid,
  input  logic [ROB_IW-1:0]        release_slot_idx
);

  logic          [ROB_NW-1:0]            valid_q;
  logic          [ROB_NW-1:0][LAT_W-1:0] cnt_q;
  logic          [ROB_NW-1:0][ROB_IW-1:0] user_q;
  resp_payload_t [ROB_NW-1:0]            payload_q;

  logic              free_any;
  logic [ROB_IW-1:0] free_idx;
  logic              accept;
  logic [LAT_W-1:0]  lat_load;
  resp_payload_t     new_payload;

  // Lowest free slot, scanned from the top down
  always_comb begin
    free_any = 1'b0;
    free_idx = '0;
    for (int i = ROB_NW-1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_any = 1'b1;
        free_idx = ROB_IW'(i);
      end
    end
  end

  assign tgt.req_ready = free_any;
  assign accept        = tgt.req_valid & free_any;

  // Memory access happens on the accept cycle
  assign mem_wr_en   = accept & ~tgt.req_wen;
  assign mem_wr_add  = tgt.req_add;
  assign mem_wr_be   = tgt.req_be;
  assign mem_wr_data = tgt.req_data;
  assign mem_rd_add  = tgt.req_add;

  // Writes and bad addresses return zero data
  assign new_payload.data = (tgt.req_wen && mem_in_range) ? mem_rd_data : '0;
  assign new_payload.opc  = ~mem_in_range;

  // Expiry LAT_BASE + LAT_STEP * bank cycles after accept
  assign lat_load = LAT_W'(LAT_BASE - 1 + LAT_STEP * int'(tgt.req_add[3:2]));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      cnt_q   <= '0;
    end else begin
      for (int i = 0; i < ROB_NW; i++) begin
        if (valid_q[i] && cnt_q[i] != '0) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
      // Released slot is still valid here, so never the free one
      if (release_slot_valid) begin
        valid_q[release_slot_idx] <= 1'b0;
      end
      if (accept) begin
        valid_q[free_idx] <= 1'b1;
        cnt_q[free_idx]   <= lat_load;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      user_q[free_idx]    <= tgt.req_user;
      payload_q[free_idx] <= new_payload;
    end
  end

  always_comb begin
    for (int i = 0; i < ROB_NW; i++) begin
      expired[i] = valid_q[i] & (cnt_q[i] == '0);
      entries[i] = '{payload: payload_q[i], user: user_q[i], valid: valid_q[i]};
    end
  end

  // Buffer depth equals the slot count, so it stops offering before all slots fill
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    tgt.req_valid |-> !(&valid_q));

  // Return FSM only releases slots whose delay has run out
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    release_slot_valid |-> expired[release_slot_idx]);

endmodule

`default_nettype wire

// File: hw/mem_array.sv
//////////////////////////////
// Word memory of the target
// Byte-enable writes, combinational read, range flag
//////////////////////////////

`default_nettype none

module mem_array
  import outstanding_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          wr_en,
  input  logic [AW-1:0] wr_add,
  input  logic [BW-1:0] wr_be,
  input  logic [DW-1:0] wr_data,
  input  logic [AW-1:0] rd_add,
  output logic [DW-1:0] rd_data,
  output logic          in_range
);

  logic [MEM_WORDS-1:0][DW-1:0] mem_q;
  logic [MEM_IW-1:0]            wr_idx, rd_idx;
  logic                         wr_in_range;

  // Word index from add[9:2]
  assign wr_idx = wr_add[MEM_IW+1:2];
  assign rd_idx = rd_add[MEM_IW+1:2];

  // Bits above the word index must be clear
  assign wr_in_range = (wr_add[AW-1:MEM_IW+2] == '0);
  assign in_range    = (rd_add[AW-1:MEM_IW+2] == '0);

  assign rd_data = mem_q[rd_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (wr_en && wr_in_range) begin
      // Only enabled lanes change
      for (int b = 0; b < BW; b++) begin
        if (wr_be[b]) begin
          mem_q[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/outstanding_intf.sv
//////////////////////////////
// Request/response bus between the reorder buffer and the target
// Valid/ready on both directions, req_wen high means read
//////////////////////////////

`default_nettype none

interface outstanding_intf
  import outstanding_pkg::*;
();

  // Request side
  logic [AW-1:0] req_add;
  logic          req_wen;
  logic [BW-1:0] req_be;
  logic [DW-1:0] req_data;
  logic [UW-1:0] req_user;
  logic [IW-1:0] req_id;
  logic          req_valid;
  logic          req_ready;

  // Response side
  logic [DW-1:0] resp_data;
  logic          resp_opc;
  logic [UW-1:0] resp_user;
  logic [IW-1:0] resp_id;
  logic          resp_valid;
  logic          resp_ready;

  // Issues requests, accepts responses
  modport initiator (
    output req_add, req_wen, req_be, req_data, req_user, req_id, req_valid,
    input  req_ready,
    input  resp_data, resp_opc, resp_user, resp_id, resp_valid,
    output resp_ready
  );

  // Serves requests, returns responses
  modport target (
    input  req_add, req_wen, req_be, req_data, req_user, req_id, req_valid,
    output req_ready,
    output resp_data, resp_opc, resp_user, resp_id, resp_valid,
    input  resp_ready
  );

endinterface

`default_nettype wire

// File: hw/outstanding_pkg.sv
//////////////////////////////
// Shared sizes, latency rule and response payload types
// Imported by every block of the outstanding subsystem
//////////////////////////////

`default_nettype none

package outstanding_pkg;

  // Bus widths
  localparam int unsigned AW = 32;
  localparam int unsigned DW = 32;
  localparam int unsigned BW = 4;
  localparam int unsigned IW = 4;

  // Reorder buffer and target slot count
  localparam int unsigned ROB_NW = 8;
  localparam int unsigned ROB_IW = 3;
  // User field carries the slot tag
  localparam int unsigned UW     = ROB_IW;

  // Word memory, index taken from add[9:2]
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_IW    = $clog2(MEM_WORDS);

  // Response delay is LAT_BASE + LAT_STEP * bank
  localparam int unsigned LAT_BASE = 1;
  localparam int unsigned LAT_STEP = 2;
  // Countdown width, wide enough for bank 3
  localparam int unsigned LAT_W    = 3;

  typedef struct packed {
    logic [DW-1:0] data;
    logic          opc;
  } resp_payload_t;

  typedef struct packed {
    resp_payload_t     payload;
    logic [ROB_IW-1:0] user;
    logic              valid;
  } slot_entry_t;

endpackage

`default_nettype wire

// File: hw/outstanding_rob.sv
//////////////////////////////
// Reorder buffer, tags each request with a slot in req_user
// and hands responses back to the requester in issue order
//////////////////////////////

`default_nettype none

module outstanding_rob
  import outstanding_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Requester side
  input  logic [AW-1:0]        in_req_add,
  input  logic                 in_req_wen,
  input  logic [BW-1:0]        in_req_be,
  input  logic [DW-1:0]        in_req_data,
  input  logic [IW-1:0]        in_req_id,
  input  logic                 in_req_valid,
  output logic                 in_req_ready,
  output logic [DW-1:0]        in_resp_data,
  output logic                 in_resp_opc,
  output logic [IW-1:0]        in_resp_id,
  output logic                 in_resp_valid,
  input  logic                 in_resp_ready,

  // Memory target side
  outstanding_intf.initiator   out
);

  // Pointers and occupancy, count one bit wider so all slots fill
  logic [ROB_IW-1:0] wr_ptr_p, wr_ptr_q;
  logic [ROB_IW-1:0] rd_ptr_p, rd_ptr_q;
  logic [ROB_IW:0]   cnt_p, cnt_q;
  logic              full, empty;
  logic              request, push, pop;

  // Slot storage
  logic          [ROB_NW-1:0][IW-1:0] id_q;
  resp_payload_t [ROB_NW-1:0]         resp_q;
  logic          [ROB_NW-1:0]         valid_q;

  assign full  = (cnt_q == (ROB_IW+1)'(ROB_NW));
  assign empty = (cnt_q == '0);

  // Request forwarded unchanged apart from the tag
  assign out.req_add   = in_req_add;
  assign out.req_wen   = in_req_wen;
  assign out.req_be    = in_req_be;
  assign out.req_data  = in_req_data;
  assign out.req_user  = wr_ptr_q;
  assign out.req_id    = in_req_id;
  assign out.req_valid = in_req_valid & ~full;
  assign in_req_ready  = out.req_ready & ~full;

  // Head slot toward the requester
  assign in_resp_data  = resp_q[rd_ptr_q].data;
  assign in_resp_opc   = resp_q[rd_ptr_q].opc;
  assign in_resp_id    = id_q[rd_ptr_q];
  assign in_resp_valid = valid_q[rd_ptr_q];

  // Every outstanding request owns a slot, so accept whenever one exists
  assign out.resp_ready = ~empty;

  assign request = in_req_valid & in_req_ready;
  assign push    = out.resp_valid & out.resp_ready;
  assign pop     = in_resp_valid & in_resp_ready;

  always_comb begin
    wr_ptr_p = wr_ptr_q;
    rd_ptr_p = rd_ptr_q;
    cnt_p    = cnt_q;
    if (request) begin
      // Wrap at the last slot
      wr_ptr_p = (wr_ptr_q == ROB_IW'(ROB_NW-1)) ? '0 : wr_ptr_q + 1'b1;
      cnt_p    = cnt_q + 1'b1;
    end
    if (pop) begin
      rd_ptr_p = (rd_ptr_q == ROB_IW'(ROB_NW-1)) ? '0 : rd_ptr_q + 1'b1;
      cnt_p    = cnt_q - 1'b1;
    end
    // Issue and retire together
    if (request && pop) begin
      cnt_p = cnt_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      valid_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_p;
      rd_ptr_q <= rd_ptr_p;
      cnt_q    <= cnt_p;
      // Push and pop never hit the same slot
      if (push) begin
        valid_q[out.resp_user] <= 1'b1;
      end
      if (pop) begin
        valid_q[rd_ptr_q] <= 1'b0;
      end
    end
  end

  // Requester ID and response payload
  always_ff @(posedge clk_i) begin
    if (request) begin
      id_q[wr_ptr_q] <= in_req_id;
    end
    if (push) begin
      resp_q[out.resp_user] <= '{data: out.resp_data, opc: out.resp_opc};
    end
  end

  // Target must return each tag once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> !valid_q[out.resp_user]);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= (ROB_IW+1)'(ROB_NW));

endmodule

`default_nettype wire

// File: hw/outstanding_top.sv
//////////////////////////////
// Top level, requester ports in, reorder buffer in front
// of the memory, timer and return FSM
//////////////////////////////

`default_nettype none

module outstanding_top
  import outstanding_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic [AW-1:0] req_add,
  input  logic          req_wen,
  input  logic [BW-1:0] req_be,
  input  logic [DW-1:0] req_data,
  input  logic [IW-1:0] req_id,
  input  logic          req_valid,
  output logic          req_ready,
  output logic [DW-1:0] resp_data,
  output logic          resp_opc,
  output logic [IW-1:0] resp_id,
  output logic          resp_valid,
  input  logic          resp_ready
);

  // Target internals
  logic                     mem_wr_en;
  logic [AW-1:0]            mem_wr_add;
  logic [BW-1:0]            mem_wr_be;
  logic [DW-1:0]            mem_wr_data;
  logic [AW-1:0]            mem_rd_add;
  logic [DW-1:0]            mem_rd_data;
  logic                     mem_in_range;
  logic [ROB_NW-1:0]        expired;
  slot_entry_t [ROB_NW-1:0] entries;
  logic                     release_slot_valid;
  logic [ROB_IW-1:0]        release_slot_idx;

  outstanding_intf mem_if ();

  outstanding_rob outstanding_rob_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_req_add    (req_add),
    .in_req_wen    (req_wen),
    .in_req_be     (req_be),
    .in_req_data   (req_data),
    .in_req_id     (req_id),
    .in_req_valid  (req_valid),
    .in_req_ready  (req_ready),
    .in_resp_data  (resp_data),
    .in_resp_opc   (resp_opc),
    .in_resp_id    (resp_id),
    .in_resp_valid (resp_valid),
    .in_resp_ready (resp_ready),
    .out           (mem_if.initiator)
  );

  mem_array mem_array_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_en    (mem_wr_en),
    .wr_add   (mem_wr_add),
    .wr_be    (mem_wr_be),
    .wr_data  (mem_wr_data),
    .rd_add   (mem_rd_add),
    .rd_data  (mem_rd_data),
    .in_range (mem_in_range)
  );

  // Request side of mem_if
  latency_timer latency_timer_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .tgt                (mem_if.target),
    .mem_wr_en          (mem_wr_en),
    .mem_wr_add         (mem_wr_add),
    .mem_wr_be          (mem_wr_be),
    .mem_wr_data        (mem_wr_data),
    .mem_rd_add         (mem_rd_add),
    .mem_rd_data        (mem_rd_data),
    .mem_in_range       (mem_in_range),
    .expired            (expired),
    .entries            (entries),
    .release_slot_valid (release_slot_valid),
    .release_slot_idx   (release_slot_idx)
  );

  // Response side of mem_if
  resp_return_fsm resp_return_fsm_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .expired            (expired),
    .entries            (entries),
    .release_slot_valid (release_slot_valid),
    .release_slot_idx   (release_slot_idx),
    .tgt                (mem_if.target)
  );

endmodule

`default_nettype wire

// File: hw/resp_return_fsm.sv
//////////////////////////////
// Response side of the target, sends expired slots
// one at a time, lowest index first
//////////////////////////////

`default_nettype none

module resp_return_fsm
  import outstanding_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [ROB_NW-1:0]        expired,
  input  slot_entry_t [ROB_NW-1:0] entries,
  output logic                     release_slot_valid,
  output logic [ROB_IW-1:0]        release_slot_idx,

  // Response side of the target
  outstanding_intf.target          tgt
);

  typedef enum logic {
    IDLE,
    SEND
  } state_t;

  state_t            state_p, state_q;
  logic [ROB_IW-1:0] sel_p, sel_q;
  logic              any_expired;
  logic [ROB_IW-1:0] low_idx;

  // Lowest expired slot
  always_comb begin
    any_expired = 1'b0;
    low_idx     = '0;
    for (int i = ROB_NW-1; i >= 0; i--) begin
      if (expired[i]) begin
        any_expired = 1'b1;
        low_idx     = ROB_IW'(i);
      end
    end
  end

  always_comb begin
    state_p = state_q;
    sel_p   = sel_q;
    case (state_q)
      IDLE: begin
        if (any_expired) begin
          sel_p   = low_idx;
          state_p = SEND;
        end
      end
      SEND: begin
        // Slot is freed on the handshake
        if (tgt.resp_ready) begin
          state_p = IDLE;
        end
      end
      default: state_p = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      sel_q   <= '0;
    end else begin
      state_q <= state_p;
      sel_q   <= sel_p;
    end
  end

  // Payload held in the slot until release
  assign tgt.resp_valid = (state_q == SEND);
  assign tgt.resp_data  = entries[sel_q].payload.data;
  assign tgt.resp_opc   = entries[sel_q].payload.opc;
  assign tgt.resp_user  = entries[sel_q].user;
  // Requester IDs are restored by the buffer
  assign tgt.resp_id    = '0;

  assign release_slot_valid = (state_q == SEND) & tgt.resp_ready;
  assign release_slot_idx   = sel_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tgt.resp_valid && !tgt.resp_ready) |=>
      (tgt.resp_valid && $stable(tgt.resp_data) && $stable(tgt.resp_opc) &&
       $stable(tgt.resp_user)));

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
//////////////////////////////
// Testbench clock and reset source
// 8 ns clock, reset held low for 3 cycles
//////////////////////////////

`default_nettype none

module tb_clk_gen (
  output logic clk_i,
  output logic rst_ni
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned HALF_NS = 4;

  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

  always #(HALF_NS) clk_i = ~clk_i;

endmodule

`default_nettype wire

// File: sim/tb_outstanding_top.sv
//////////////////////////////
// Directed testbench for the outstanding subsystem
// Reference memory and in-order response queue check every reply
//////////////////////////////

`default_nettype none

module tb_outstanding_top
  import outstanding_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic RD = 1'b1;
  localparam logic WR = 1'b0;
  localparam int unsigned N_RANDOM = 200;
  // Upper bound on requests over all tests, and cycles allowed per request
  localparam int unsigned MAX_REQS    = 250;
  localparam int unsigned CYC_PER_REQ = 100;
  localparam int unsigned WATCHDOG_NS = MAX_REQS * CYC_PER_REQ * 8;

  typedef struct packed {
    logic [IW-1:0] id;
    logic [DW-1:0] data;
    logic          opc;
  } exp_resp_t;

  logic          clk_i;
  logic          rst_ni;
  logic [AW-1:0] req_add;
  logic          req_wen;
  logic [BW-1:0] req_be;
  logic [DW-1:0] req_data;
  logic [IW-1:0] req_id;
  logic          req_valid;
  logic          req_ready;
  logic [DW-1:0] resp_data;
  logic          resp_opc;
  logic [IW-1:0] resp_id;
  logic          resp_valid;
  logic          resp_ready;

  // Reference state
  logic [DW-1:0] ref_mem [MEM_WORDS];
  exp_resp_t     exp_q[$];
  int            err_cnt = 0;
  int            n_req   = 0;
  int            n_resp  = 0;
  int            seed    = 15;

  // resp_ready source: random or a fixed level
  logic rand_ready_en;
  logic hold_ready;

  tb_clk_gen tb_clk_gen_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni)
  );

  outstanding_top outstanding_top_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_add    (req_add),
    .req_wen    (req_wen),
    .req_be     (req_be),
    .req_data   (req_data),
    .req_id     (req_id),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_data  (resp_data),
    .resp_opc   (resp_opc),
    .resp_id    (resp_id),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  always @(posedge clk_i) begin
    if (rand_ready_en) begin
      resp_ready <= 1'($random(seed));
    end else begin
      resp_ready <= hold_ready;
    end
  end

  // Accepted request, update model in acceptance order
  task automatic model_accept();
    exp_resp_t         e;
    logic [MEM_IW-1:0] idx;
    logic              ok;
    idx   = req_add[9:2];
    ok    = (req_add[AW-1:10] == '0);
    e.id  = req_id;
    e.opc = ~ok;
    e.data = '0;
    if (ok && req_wen) begin
      e.data = ref_mem[idx];
    end
    // Write lands only on enabled bytes
    if (ok && !req_wen) begin
      for (int b = 0; b < BW; b++) begin
        if (req_be[b]) begin
          ref_mem[idx][8*b +: 8] = req_data[8*b +: 8];
        end
      end
    end
    exp_q.push_back(e);
    n_req++;
  endtask

  // Response must match oldest outstanding request
  task automatic check_resp();
    exp_resp_t e;
    if (exp_q.size() == 0) begin
      err_cnt++;
      $display("Error at %0t: response arrived with no request outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      n_resp++;
      if (resp_id !== e.id) begin
        err_cnt++;
        $display("Fail %0t: resp_id expected %h got %h", $time, e.id, resp_id);
      end
      if (resp_data !== e.data) begin
        err_cnt++;
        $display("Fail %0t: resp_data expected %h got %h", $time, e.data, resp_data);
      end
      if (resp_opc !== e.opc) begin
        err_cnt++;
        $display("Fail %0t: resp_opc expected %h got %h", $time, e.opc, resp_opc);
      end
    end
  endtask

  // Sample on falling edge, handshakes settle there
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (req_valid && req_ready) begin
        model_accept();
      end
      if (resp_valid && resp_ready) begin
        check_resp();
      end
    end
  end

  // Presents a request and returns once the DUT takes it
  task automatic send_req(input logic [AW-1:0] add, input logic wen,
                          input logic [BW-1:0] be, input logic [DW-1:0] data,
                          input logic [IW-1:0] id);
    @(posedge clk_i);
    req_add   <= add;
    req_wen   <= wen;
    req_be    <= be;
    req_data  <= data;
    req_id    <= id;
    req_valid <= 1'b1;
    do begin
      @(negedge clk_i);
    end while (!req_ready);
  endtask

  task automatic end_reqs();
    @(posedge clk_i);
    req_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  // Changed between edges so the ready process sees it cleanly
  task automatic set_ready_mode(input logic rand_en, input logic level);
    @(negedge clk_i);
    rand_ready_en = rand_en;
    hold_ready    = level;
  endtask

  task automatic test_write_read();
    send_req(32'h10, WR, 4'hf, 32'hcafe_0001, 4'd1);
    send_req(32'h10, RD, 4'hf, 32'h0, 4'd2);
    end_reqs();
    wait_drain();
  endtask

  task automatic test_out_of_order();
    // Fill bank 0..3 words first
    for (int k = 0; k < 4; k++) begin
      send_req(32'h40 + 4*k, WR, 4'hf, 32'ha0a0_0000 + k, 4'(8 + k));
    end
    end_reqs();
    wait_drain();
    // Longest bank first, so the target answers in reverse
    for (int k = 0; k < 4; k++) begin
      send_req(32'h4c - 4*k, RD, 4'hf, 32'h0, 4'(k));
    end
    end_reqs();
    wait_drain();
  endtask

  task automatic test_byte_enable();
    send_req(32'h80, WR, 4'hf, 32'h1122_3344, 4'd5);
    send_req(32'h80, WR, 4'b0101, 32'haabb_ccdd, 4'd6);
    send_req(32'h80, RD, 4'hf, 32'h0, 4'd7);
    end_reqs();
    wait_drain();
  endtask

  task automatic test_out_of_range();
    send_req(32'h0, WR, 4'hf, 32'h5a5a_5a5a, 4'd3);
    // Aliases word 0 if the range check were missing
    send_req(32'h400, WR, 4'hf, 32'hffff_ffff, 4'd4);
    send_req(32'h8000_0000, RD, 4'hf, 32'h0, 4'd5);
    send_req(32'h0, RD, 4'hf, 32'h0, 4'd6);
    end_reqs();
    wait_drain();
  endtask

  task automatic test_backpressure();
    int n_acc;
    int stall;
    n_acc = 0;
    stall = 0;
    set_ready_mode(1'b0, 1'b0);
    @(posedge clk_i);
    req_add   <= '0;
    req_wen   <= RD;
    req_be    <= 4'hf;
    req_data  <= '0;
    req_id    <= '0;
    req_valid <= 1'b1;
    // Keep offering until ready stays low for a while
    while (stall < 16) begin
      @(negedge clk_i);
      if (req_ready) begin
        n_acc++;
        stall = 0;
        @(posedge clk_i);
        req_add <= AW'(n_acc) << 2;
        req_id  <= IW'(n_acc);
      end else begin
        stall++;
      end
    end
    hold_ready = 1'b1;
    end_reqs();
    if (n_acc != ROB_NW) begin
      err_cnt++;
      $display("Fail %0t: accepted_count expected %0d got %0d", $time, ROB_NW, n_acc);
    end
    wait_drain();
  endtask

  task automatic test_random_mix();
    logic [31:0]   r;
    logic [AW-1:0] add;
    logic [DW-1:0] data;
    set_ready_mode(1'b1, 1'b1);
    for (int n = 0; n < N_RANDOM; n++) begin
      r    = $random(seed);
      data = $random(seed);
      // 64 words, bank from the low index bits
      add  = AW'(r[5:0]) << 2;
      if (r[31:28] == 4'h0) begin
        add[12] = 1'b1;
      end
      send_req(add, r[8], r[12:9], data, r[16:13]);
    end
    end_reqs();
    wait_drain();
    set_ready_mode(1'b0, 1'b1);
  endtask

  initial begin
    req_add       = '0;
    req_wen       = RD;
    req_be        = '0;
    req_data      = '0;
    req_id        = '0;
    req_valid     = 1'b0;
    resp_ready    = 1'b1;
    rand_ready_en = 1'b0;
    hold_ready    = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    @(posedge rst_ni);
    @(negedge clk_i);
    // Idle state out of reset
    if (req_ready !== 1'b1) begin
      err_cnt++;
      $display("Fail %0t: req_ready expected 1 got %b", $time, req_ready);
    end
    if (resp_valid !== 1'b0) begin
      err_cnt++;
      $display("Fail %0t: resp_valid expected 0 got %b", $time, resp_valid);
    end
    test_write_read();
    test_out_of_order();
    test_byte_enable();
    test_out_of_range();
    test_backpressure();
    test_random_mix();
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d, requests accepted: %0d, responses checked: %0d",
             err_cnt, n_req, n_resp);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns, %0d responses outstanding",
             WATCHDOG_NS, exp_q.size());
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
